/* list.f */
+incdir+include
hdl/sram_pkg.sv
hdl/axi_cmd_queue.sv
hdl/axi_burst_addr.sv
hdl/sram_mem.sv
hdl/sram_read_ctrl.sv
hdl/sram_write_ctrl.sv
hdl/sram_axi4.sv
tests/tb_clock.sv
tests/tb_sram_axi4.sv

/* tests/sram_cases.txt */
# op id addr len size burst data_base strb resp, all fields hex after op
# len is beats-1, burst 0 FIXED 1 INCR 2 WRAP, resp 0 OKAY 2 SLVERR
R 1 028 00 3 1 0000000000000000 00 0
W 2 100 03 3 1 a5a5a5a500000000 f0 0
R 3 104 03 3 1 0000000000000000 00 0
W 4 200 03 3 0 1111222233334440 ff 0
R 5 200 01 3 1 0000000000000000 00 0
R 6 090 03 3 2 0000000000000000 00 0
W 7 300 01 2 1 ffffffffffffffff ff 2
R 8 300 01 3 1 0000000000000000 00 0
W 9 308 02 3 2 eeeeeeeeeeeeeeee ff 2
R a 308 00 3 1 0000000000000000 00 0
R b 040 02 3 2 0000000000000000 00 2
R c 040 03 2 1 0000000000000000 00 2
W d 7f0 03 3 1 deadbeef00000000 ff 0
R e 7f0 07 3 1 0000000000000000 00 0
R f 000 0f 3 1 0000000000000000 00 0
W 1 440 0f 3 2 0123456789ab0000 3c 0
R 2 440 0f 3 2 0000000000000000 00 0

/* tests/tb_sram_axi4.sv */
`include "sram_defines.svh"

module tb_sram_axi4;

    localparam int ADDR_SPAN = 1 << `SRAM_ADDR_W;

    typedef struct packed {
        logic [7:0]              op;
        logic [`SRAM_ID_W-1:0]   id;
        logic [`SRAM_ADDR_W-1:0] addr;
        logic [7:0]              len;
        logic [2:0]              size;
        logic [1:0]              burst;
        logic [`SRAM_DATA_W-1:0] base;
        logic [`SRAM_STRB_W-1:0] strb;
        logic [1:0]              resp;
    } case_t;

    logic aclk;
    logic areset_n;

    logic [`SRAM_ID_W-1:0]   arid;
    logic [`SRAM_ADDR_W-1:0] araddr;
    logic [7:0]              arlen;
    logic [2:0]              arsize;
    logic [1:0]              arburst;
    logic                    arvalid;
    logic                    arready;
    logic [`SRAM_ID_W-1:0]   rid;
    logic [`SRAM_DATA_W-1:0] rdata;
    logic [1:0]              rresp;
    logic                    rlast;
    logic                    rvalid;
    logic                    rready;
    logic [`SRAM_ID_W-1:0]   awid;
    logic [`SRAM_ADDR_W-1:0] awaddr;
    logic [7:0]              awlen;
    logic [2:0]              awsize;
    logic [1:0]              awburst;
    logic                    awvalid;
    logic                    awready;
    logic [`SRAM_DATA_W-1:0] wdata;
    logic [`SRAM_STRB_W-1:0] wstrb;
    logic                    wlast;
    logic                    wvalid;
    logic                    wready;
    logic [`SRAM_ID_W-1:0]   bid;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    bready;

    case_t                   cases [$];
    logic [`SRAM_DATA_W-1:0] model [`SRAM_DEPTH];
    // Expected R beats in arrival order
    logic [`SRAM_DATA_W-1:0] exp_data [$];
    logic [`SRAM_ID_W-1:0]   exp_id [$];
    logic [1:0]              exp_resp [$];
    logic                    exp_last [$];
    int                      total_beats = 0;
    int                      limit = 0;
    int                      cycles = 0;
    integer                  seed = 11;

    tb_clock u_tb_clock (
        .o_aclk     (aclk),
        .o_areset_n (areset_n)
    );

    sram_axi4 u_sram_axi4 (
        .i_aclk (aclk), .i_areset_n (areset_n),
        .i_arid (arid), .i_araddr (araddr), .i_arlen (arlen), .i_arsize (arsize),
        .i_arburst (arburst), .i_arvalid (arvalid), .o_arready (arready),
        .o_rid (rid), .o_rdata (rdata), .o_rresp (rresp), .o_rlast (rlast),
        .o_rvalid (rvalid), .i_rready (rready),
        .i_awid (awid), .i_awaddr (awaddr), .i_awlen (awlen), .i_awsize (awsize),
        .i_awburst (awburst), .i_awvalid (awvalid), .o_awready (awready),
        .i_wdata (wdata), .i_wstrb (wstrb), .i_wlast (wlast), .i_wvalid (wvalid),
        .o_wready (wready),
        .o_bid (bid), .o_bresp (bresp), .o_bvalid (bvalid), .i_bready (bready)
    );

    // ========================================================================
    // Reporting and address rules
    // ========================================================================
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic int word_index(input logic [`SRAM_ADDR_W-1:0] addr);
        return int'(addr) / 8;
    endfunction

    function automatic logic [`SRAM_ADDR_W-1:0] next_addr(input logic [`SRAM_ADDR_W-1:0] addr,
                                                         input logic [7:0] len,
                                                         input logic [1:0] burst);
        int unsigned aligned;
        int unsigned span;
        int unsigned low;
        int unsigned nxt;
        aligned = (int'(addr) / 8) * 8;
        span    = (int'(len) + 1) * 8;
        low     = (aligned / span) * span;
        case (burst)
            2'b00: nxt = addr;
            2'b10: begin
                // Back to the container start after its top word
                nxt = aligned + 8;
                if (nxt >= low + span) begin
                    nxt = low;
                end
            end
            default: nxt = aligned + 8;
        endcase
        return `SRAM_ADDR_W'(nxt % ADDR_SPAN);
    endfunction

    // ========================================================================
    // Case file
    // ========================================================================
    task automatic read_cases();
        int                      fd;
        int                      n;
        string                   line;
        case_t                   c;
        logic [7:0]              op;
        logic [`SRAM_ID_W-1:0]   id;
        logic [`SRAM_ADDR_W-1:0] addr;
        logic [7:0]              len;
        logic [2:0]              size;
        logic [1:0]              burst;
        logic [`SRAM_DATA_W-1:0] base;
        logic [`SRAM_STRB_W-1:0] strb;
        logic [1:0]              resp;
        fd = $fopen("tests/sram_cases.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the case file tests/sram_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h %h %h %h %h %h %h",
                                op, id, addr, len, size, burst, base, strb, resp);
                    if (n != 9) begin
                        abort_run($sformatf("Case line could not be parsed: %s", line));
                    end else begin
                        c.op    = op;
                        c.id    = id;
                        c.addr  = addr;
                        c.len   = len;
                        c.size  = size;
                        c.burst = burst;
                        c.base  = base;
                        c.strb  = strb;
                        c.resp  = resp;
                        cases.push_back(c);
                        total_beats += int'(len) + 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ========================================================================
    // Channel drivers
    // ========================================================================
    task automatic issue_read(input case_t c);
        logic [`SRAM_ADDR_W-1:0] a;
        int k;
        a = c.addr;
        // Expected beats taken from the model before the burst starts
        for (k = 0; k <= c.len; k++) begin
            exp_id.push_back(c.id);
            exp_resp.push_back(c.resp);
            exp_last.push_back(k == c.len);
            exp_data.push_back(c.resp == 2'b00 ? model[word_index(a)] : 64'd0);
            a = next_addr(a, c.len, c.burst);
        end
        arid    = c.id;
        araddr  = c.addr;
        arlen   = c.len;
        arsize  = c.size;
        arburst = c.burst;
        arvalid = 1'b1;
        @(posedge aclk);
        while (!arready) @(posedge aclk);
        #1;
        arvalid = 1'b0;
    endtask

    task automatic run_write(input case_t c);
        logic [`SRAM_ADDR_W-1:0] a;
        logic [`SRAM_DATA_W-1:0] data;
        int k;
        int b;
        awid    = c.id;
        awaddr  = c.addr;
        awlen   = c.len;
        awsize  = c.size;
        awburst = c.burst;
        awvalid = 1'b1;
        @(posedge aclk);
        while (!awready) @(posedge aclk);
        #1;
        awvalid = 1'b0;
        a = c.addr;
        for (k = 0; k <= c.len; k++) begin
            data   = c.base + k;
            wdata  = data;
            wstrb  = c.strb;
            wlast  = (k == c.len);
            wvalid = 1'b1;
            @(posedge aclk);
            while (!wready) @(posedge aclk);
            #1;
            // Erroring bursts leave memory alone
            if (c.resp == 2'b00) begin
                for (b = 0; b < `SRAM_STRB_W; b++) begin
                    if (c.strb[b]) begin
                        model[word_index(a)][8*b +: 8] = data[8*b +: 8];
                    end
                end
            end
            a = next_addr(a, c.len, c.burst);
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        @(posedge aclk);
        while (!bvalid) @(posedge aclk);
        check_value("o_bid", bid, c.id);
        check_value("o_bresp", bresp, c.resp);
        #1;
    endtask

    task automatic wait_reads_done();
        while (exp_data.size() != 0) begin
            @(posedge aclk);
            #1;
        end
    endtask

    // ========================================================================
    // Stimulus, monitor and timeout
    // ========================================================================
    initial begin
        arid = '0;
        araddr = '0;
        arlen = '0;
        arsize = '0;
        arburst = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        awid = '0;
        awaddr = '0;
        awlen = '0;
        awsize = '0;
        awburst = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wlast = 1'b0;
        wvalid = 1'b0;
        bready = 1'b0;
        for (int i = 0; i < `SRAM_DEPTH; i++) begin
            model[i] = `SRAM_DATA_W'(i);
        end
        read_cases();
        limit = 200 + 20 * total_beats;
        wait (areset_n === 1'b1);
        @(posedge aclk);
        #1;
        // Idle state straight after reset
        check_value("o_rvalid", rvalid, 1'b0);
        check_value("o_bvalid", bvalid, 1'b0);
        check_value("o_wready", wready, 1'b0);
        check_value("o_arready", arready, 1'b1);
        check_value("o_awready", awready, 1'b1);
        bready = 1'b1;
        foreach (cases[i]) begin
            if (cases[i].op == "W") begin
                wait_reads_done();
                run_write(cases[i]);
            end else begin
                issue_read(cases[i]);
            end
        end
        wait_reads_done();
        repeat (4) @(posedge aclk);
        $display("TB PASSED");
        $finish;
    end

    // Random R back-pressure with ready about 3 cycles in 4
    always @(posedge aclk) begin
        #1;
        rready = (($random(seed) & 3) != 0);
    end

    always @(posedge aclk) begin
        if (areset_n && rvalid && rready) begin
            if (exp_data.size() == 0) begin
                abort_run("An R beat arrived while no read burst was outstanding");
            end else begin
                check_value("o_rid", rid, exp_id.pop_front());
                check_value("o_rresp", rresp, exp_resp.pop_front());
                check_value("o_rlast", rlast, exp_last.pop_front());
                check_value("o_rdata", rdata, exp_data.pop_front());
            end
        end
    end

    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (limit != 0 && cycles > limit) begin
            abort_run($sformatf("Timeout: the run did not finish within %0d cycles", limit));
        end
    end

endmodule

/* tests/tb_clock.sv */
module tb_clock (
    output logic o_aclk,
    output logic o_areset_n
);

    // 4 unit period
    initial begin
        o_aclk = 1'b0;
        forever #2 o_aclk = !o_aclk;
    end

    // Reset held low for 8 rising edges
    initial begin
        o_areset_n = 1'b0;
        repeat (8) @(posedge o_aclk);
        #1 o_areset_n = 1'b1;
    end

endmodule

/* hdl/sram_axi4.sv */
`include "sram_defines.svh"

module sram_axi4 (
    input  logic                    i_aclk,
    input  logic                    i_areset_n,
    // Read address
    input  logic [`SRAM_ID_W-1:0]   i_arid,
    input  logic [`SRAM_ADDR_W-1:0] i_araddr,
    input  logic [7:0]              i_arlen,
    input  logic [2:0]              i_arsize,
    input  logic [1:0]              i_arburst,
    input  logic                    i_arvalid,
    output logic                    o_arready,
    // Read data
    output logic [`SRAM_ID_W-1:0]   o_rid,
    output logic [`SRAM_DATA_W-1:0] o_rdata,
    output logic [1:0]              o_rresp,
    output logic                    o_rlast,
    output logic                    o_rvalid,
    input  logic                    i_rready,
    // Write address
    input  logic [`SRAM_ID_W-1:0]   i_awid,
    input  logic [`SRAM_ADDR_W-1:0] i_awaddr,
    input  logic [7:0]              i_awlen,
    input  logic [2:0]              i_awsize,
    input  logic [1:0]              i_awburst,
    input  logic                    i_awvalid,
    output logic                    o_awready,
    // Write data
    input  logic [`SRAM_DATA_W-1:0] i_wdata,
    input  logic [`SRAM_STRB_W-1:0] i_wstrb,
    input  logic                    i_wlast,
    input  logic                    i_wvalid,
    output logic                    o_wready,
    // Write response
    output logic [`SRAM_ID_W-1:0]   o_bid,
    output logic [1:0]              o_bresp,
    output logic                    o_bvalid,
    input  logic                    i_bready
);

    sram_pkg::addr_cmd_t     w_ar_cmd;
    sram_pkg::addr_cmd_t     w_ar_q_cmd;
    logic                    w_ar_q_valid;
    logic                    w_ar_pop;
    sram_pkg::addr_cmd_t     w_aw_cmd;
    sram_pkg::addr_cmd_t     w_aw_q_cmd;
    logic                    w_aw_q_valid;
    logic                    w_aw_pop;
    logic                    w_rd_en;
    logic [`SRAM_ADDR_W-1:0] w_rd_addr;
    logic [`SRAM_DATA_W-1:0] w_rd_data;
    logic                    w_wr_en;
    logic [`SRAM_ADDR_W-1:0] w_wr_addr;
    logic [`SRAM_DATA_W-1:0] w_wr_data;
    logic [`SRAM_STRB_W-1:0] w_wr_strb;

    assign w_ar_cmd = '{id: i_arid, addr: i_araddr, len: i_arlen, size: i_arsize,
                        burst: sram_pkg::burst_e'(i_arburst)};
    assign w_aw_cmd = '{id: i_awid, addr: i_awaddr, len: i_awlen, size: i_awsize,
                        burst: sram_pkg::burst_e'(i_awburst)};

    // ======================================================================
    // Address command queues
    // ======================================================================
    axi_cmd_queue #(.payload_t(sram_pkg::addr_cmd_t)) u_ar_queue (
        .i_aclk       (i_aclk),
        .i_areset_n   (i_areset_n),
        .i_push_valid (i_arvalid),
        .o_push_ready (o_arready),
        .i_push_data  (w_ar_cmd),
        .o_pop_valid  (w_ar_q_valid),
        .o_pop_data   (w_ar_q_cmd),
        .i_pop        (w_ar_pop)
    );

    axi_cmd_queue #(.payload_t(sram_pkg::addr_cmd_t)) u_aw_queue (
        .i_aclk       (i_aclk),
        .i_areset_n   (i_areset_n),
        .i_push_valid (i_awvalid),
        .o_push_ready (o_awready),
        .i_push_data  (w_aw_cmd),
        .o_pop_valid  (w_aw_q_valid),
        .o_pop_data   (w_aw_q_cmd),
        .i_pop        (w_aw_pop)
    );

    // ======================================================================
    // Burst controllers and storage
    // ======================================================================
    sram_read_ctrl u_read_ctrl (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_q_valid  (w_ar_q_valid),
        .i_q_cmd    (w_ar_q_cmd),
        .o_q_pop    (w_ar_pop),
        .o_rid      (o_rid),
        .o_rdata    (o_rdata),
        .o_rresp    (o_rresp),
        .o_rlast    (o_rlast),
        .o_rvalid   (o_rvalid),
        .i_rready   (i_rready),
        .o_rd_en    (w_rd_en),
        .o_rd_addr  (w_rd_addr),
        .i_rd_data  (w_rd_data)
    );

    sram_write_ctrl u_write_ctrl (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_q_valid  (w_aw_q_valid),
        .i_q_cmd    (w_aw_q_cmd),
        .o_q_pop    (w_aw_pop),
        .i_wdata    (i_wdata),
        .i_wstrb    (i_wstrb),
        .i_wlast    (i_wlast),
        .i_wvalid   (i_wvalid),
        .o_wready   (o_wready),
        .o_bid      (o_bid),
        .o_bresp    (o_bresp),
        .o_bvalid   (o_bvalid),
        .i_bready   (i_bready),
        .o_wr_en    (w_wr_en),
        .o_wr_addr  (w_wr_addr),
        .o_wr_data  (w_wr_data),
        .o_wr_strb  (w_wr_strb)
    );

    sram_mem u_sram_mem (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_rd_en    (w_rd_en),
        .i_rd_addr  (w_rd_addr),
        .o_rd_data  (w_rd_data),
        .i_wr_en    (w_wr_en),
        .i_wr_addr  (w_wr_addr),
        .i_wr_data  (w_wr_data),
        .i_wr_strb  (w_wr_strb)
    );

endmodule

/* hdl/sram_write_ctrl.sv */
`include "sram_defines.svh"

module sram_write_ctrl (
    input  logic                    i_aclk,
    input  logic                    i_areset_n,
    input  logic                    i_q_valid,
    input  sram_pkg::addr_cmd_t     i_q_cmd,
    output logic                    o_q_pop,
    input  logic [`SRAM_DATA_W-1:0] i_wdata,
    input  logic [`SRAM_STRB_W-1:0] i_wstrb,
    input  logic                    i_wlast,
    input  logic                    i_wvalid,
    output logic                    o_wready,
    output logic [`SRAM_ID_W-1:0]   o_bid,
    output sram_pkg::resp_e         o_bresp,
    output logic                    o_bvalid,
    input  logic                    i_bready,
    output logic                    o_wr_en,
    output logic [`SRAM_ADDR_W-1:0] o_wr_addr,
    output logic [`SRAM_DATA_W-1:0] o_wr_data,
    output logic [`SRAM_STRB_W-1:0] o_wr_strb
);

    logic                  r_busy;
    logic                  r_bvalid;
    logic [`SRAM_ID_W-1:0] r_id;
    sram_pkg::resp_e       r_bresp;
    logic                  w_wshake;
    logic                  w_done;
    logic                  w_last;
    logic                  w_err;

    // Next command only once the B handshake is over
    assign o_q_pop  = i_q_valid && !r_busy && !r_bvalid;
    assign o_wready = r_busy;
    assign w_wshake = i_wvalid && r_busy;
    assign w_done   = w_wshake && w_last;

    // Bad bursts still take every W beat but write nothing
    assign o_wr_en   = w_wshake && !w_err;
    assign o_wr_data = i_wdata;
    assign o_wr_strb = i_wstrb;

    axi_burst_addr u_burst_addr (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_load     (o_q_pop),
        .i_addr     (i_q_cmd.addr),
        .i_len      (i_q_cmd.len),
        .i_size     (i_q_cmd.size),
        .i_burst    (i_q_cmd.burst),
        .i_step     (w_wshake),
        .o_addr     (o_wr_addr),
        .o_last     (w_last),
        .o_err      (w_err)
    );

    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_busy   <= 1'b0;
            r_bvalid <= 1'b0;
        end else begin
            if (o_q_pop) begin
                r_busy <= 1'b1;
            end else if (w_done) begin
                r_busy <= 1'b0;
            end
            if (w_done) begin
                r_bvalid <= 1'b1;
            end else if (i_bready) begin
                r_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_aclk) begin
        if (o_q_pop) begin
            r_id <= i_q_cmd.id;
        end
        if (w_done) begin
            r_bresp <= w_err ? sram_pkg::RESP_SLVERR : sram_pkg::RESP_OKAY;
        end
    end

    assign o_bid    = r_id;
    assign o_bresp  = r_bresp;
    assign o_bvalid = r_bvalid;

    // Master's WLAST lines up with the AW length
    a_wlast_match: assert property (@(posedge i_aclk) disable iff (!i_areset_n)
        w_wshake |-> (i_wlast == w_last));

endmodule

/* hdl/sram_read_ctrl.sv */
`include "sram_defines.svh"

module sram_read_ctrl (
    input  logic                    i_aclk,
    input  logic                    i_areset_n,
    input  logic                    i_q_valid,
    input  sram_pkg::addr_cmd_t     i_q_cmd,
    output logic                    o_q_pop,
    output logic [`SRAM_ID_W-1:0]   o_rid,
    output logic [`SRAM_DATA_W-1:0] o_rdata,
    output sram_pkg::resp_e         o_rresp,
    output logic                    o_rlast,
    output logic                    o_rvalid,
    input  logic                    i_rready,
    output logic                    o_rd_en,
    output logic [`SRAM_ADDR_W-1:0] o_rd_addr,
    input  logic [`SRAM_DATA_W-1:0] i_rd_data
);

    typedef struct packed {
        logic [`SRAM_ID_W-1:0]   id;
        logic [`SRAM_DATA_W-1:0] data;
        sram_pkg::resp_e         resp;
        logic                    last;
    } beat_t;

    logic                  r_busy;
    logic [`SRAM_ID_W-1:0] r_id;
    logic                  w_last;
    logic                  w_err;

    // Word in flight through the memory
    logic                  r_pend;
    logic                  r_pend_last;
    logic                  r_pend_err;
    logic [`SRAM_ID_W-1:0] r_pend_id;

    // R output buffer
    beat_t      r_buf [2];
    logic       r_buf_wr;
    logic       r_buf_rd;
    logic [1:0] r_buf_cnt;
    logic       w_pop;
    logic [2:0] w_used;

    assign o_q_pop = i_q_valid && !r_busy;
    assign w_pop   = o_rvalid && i_rready;
    // Slots taken after this cycle's beat leaves and the pending word lands
    assign w_used  = 3'(r_buf_cnt) + 3'(r_pend) - 3'(w_pop);
    assign o_rd_en = r_busy && (w_used < 3'd2);

    axi_burst_addr u_burst_addr (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_load     (o_q_pop),
        .i_addr     (i_q_cmd.addr),
        .i_len      (i_q_cmd.len),
        .i_size     (i_q_cmd.size),
        .i_burst    (i_q_cmd.burst),
        .i_step     (o_rd_en),
        .o_addr     (o_rd_addr),
        .o_last     (w_last),
        .o_err      (w_err)
    );

    // ======================================================================
    // Burst issue and buffer control
    // ======================================================================
    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_busy    <= 1'b0;
            r_pend    <= 1'b0;
            r_buf_wr  <= 1'b0;
            r_buf_rd  <= 1'b0;
            r_buf_cnt <= 2'd0;
        end else begin
            if (o_q_pop) begin
                r_busy <= 1'b1;
            end else if (o_rd_en && w_last) begin
                r_busy <= 1'b0;
            end
            r_pend <= o_rd_en;
            if (r_pend) begin
                r_buf_wr <= !r_buf_wr;
            end
            if (w_pop) begin
                r_buf_rd <= !r_buf_rd;
            end
            r_buf_cnt <= r_buf_cnt + 2'(r_pend) - 2'(w_pop);
        end
    end

    always_ff @(posedge i_aclk) begin
        if (o_q_pop) begin
            r_id <= i_q_cmd.id;
        end
        if (o_rd_en) begin
            r_pend_last <= w_last;
            r_pend_err  <= w_err;
            r_pend_id   <= r_id;
        end
        // Erroring bursts return zeros
        if (r_pend) begin
            r_buf[r_buf_wr] <= '{
                id:   r_pend_id,
                data: r_pend_err ? '0 : i_rd_data,
                resp: r_pend_err ? sram_pkg::RESP_SLVERR : sram_pkg::RESP_OKAY,
                last: r_pend_last
            };
        end
    end

    assign o_rvalid = (r_buf_cnt != 2'd0);
    assign o_rid    = r_buf[r_buf_rd].id;
    assign o_rdata  = r_buf[r_buf_rd].data;
    assign o_rresp  = r_buf[r_buf_rd].resp;
    assign o_rlast  = r_buf[r_buf_rd].last;

    // Stalled beat holds its payload
    a_r_hold: assert property (@(posedge i_aclk) disable iff (!i_areset_n)
        o_rvalid && !i_rready |=> o_rvalid && $stable({o_rid, o_rdata, o_rresp, o_rlast}));

endmodule

/* hdl/sram_mem.sv */
`include "sram_defines.svh"

module sram_mem (
    input  logic                    i_aclk,
    input  logic                    i_areset_n,
    input  logic                    i_rd_en,
    input  logic [`SRAM_ADDR_W-1:0] i_rd_addr,
    output logic [`SRAM_DATA_W-1:0] o_rd_data,
    input  logic                    i_wr_en,
    input  logic [`SRAM_ADDR_W-1:0] i_wr_addr,
    input  logic [`SRAM_DATA_W-1:0] i_wr_data,
    input  logic [`SRAM_STRB_W-1:0] i_wr_strb
);

    localparam int OFS_W = $clog2(`SRAM_STRB_W);
    localparam int IDX_W = $clog2(`SRAM_DEPTH);

    logic [`SRAM_DATA_W-1:0] r_mem [`SRAM_DEPTH];
    logic [IDX_W-1:0]        w_rd_idx;
    logic [IDX_W-1:0]        w_wr_idx;

    // Word index is the byte address over 8
    assign w_rd_idx = i_rd_addr[OFS_W +: IDX_W];
    assign w_wr_idx = i_wr_addr[OFS_W +: IDX_W];

    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            // Word i powers up holding i
            for (int i = 0; i < `SRAM_DEPTH; i++) begin
                r_mem[i] <= `SRAM_DATA_W'(i);
            end
        end else if (i_wr_en) begin
            for (int b = 0; b < `SRAM_STRB_W; b++) begin
                if (i_wr_strb[b]) begin
                    r_mem[w_wr_idx][8*b +: 8] <= i_wr_data[8*b +: 8];
                end
            end
        end
    end

    // One cycle read latency
    always_ff @(posedge i_aclk) begin
        if (i_rd_en) begin
            o_rd_data <= r_mem[w_rd_idx];
        end
    end

endmodule

/* hdl/axi_burst_addr.sv */
`include "sram_defines.svh"

module axi_burst_addr (
    input  logic                    i_aclk,
    input  logic                    i_areset_n,
    input  logic                    i_load,
    input  logic [`SRAM_ADDR_W-1:0] i_addr,
    input  logic [7:0]              i_len,
    input  logic [2:0]              i_size,
    input  sram_pkg::burst_e        i_burst,
    input  logic                    i_step,
    output logic [`SRAM_ADDR_W-1:0] o_addr,
    output logic                    o_last,
    output logic                    o_err
);

    logic [`SRAM_ADDR_W-1:0] r_addr;
    logic [7:0]              r_len;
    sram_pkg::burst_e        r_burst;
    logic [7:0]              r_cnt;
    logic                    r_err;
    logic [`SRAM_ADDR_W-1:0] w_base;
    logic [`SRAM_ADDR_W-1:0] w_wrap_mask;
    logic [`SRAM_ADDR_W-1:0] w_next;
    logic                    w_bad_wrap;

    // Beat address rounded down to the 8-byte word
    assign w_base      = {r_addr[`SRAM_ADDR_W-1:3], 3'b000};
    // Container of (len+1) words, aligned to its own size
    assign w_wrap_mask = `SRAM_ADDR_W'({r_len, 3'b111});
    assign w_bad_wrap  = (i_burst == sram_pkg::BURST_WRAP) && !(i_len inside {1, 3, 7, 15});

    always_comb begin
        case (r_burst)
            sram_pkg::BURST_INCR: w_next = w_base + `SRAM_ADDR_W'(8);
            sram_pkg::BURST_WRAP: w_next = (w_base & ~w_wrap_mask) |
                                           ((w_base + `SRAM_ADDR_W'(8)) & w_wrap_mask);
            default:              w_next = r_addr;
        endcase
    end

    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_cnt <= 8'd0;
            r_err <= 1'b0;
        end else if (i_load) begin
            r_cnt <= 8'd0;
            r_err <= (i_size != 3'd3) || w_bad_wrap;
        end else if (i_step) begin
            r_cnt <= r_cnt + 8'd1;
        end
    end

    always_ff @(posedge i_aclk) begin
        if (i_load) begin
            r_addr  <= i_addr;
            r_len   <= i_len;
            r_burst <= i_burst;
        end else if (i_step) begin
            r_addr <= w_next;
        end
    end

    assign o_addr = r_addr;
    assign o_last = (r_cnt == r_len);
    assign o_err  = r_err;

    // Once the final beat is stepped, no stepping until the next command
    a_no_step_past_last: assert property (@(posedge i_aclk) disable iff (!i_areset_n)
        i_step && o_last |=> !i_step until i_load);

endmodule

/* hdl/axi_cmd_queue.sv */
module axi_cmd_queue #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     i_aclk,
    input  logic     i_areset_n,
    input  logic     i_push_valid,
    output logic     o_push_ready,
    input  payload_t i_push_data,
    output logic     o_pop_valid,
    output payload_t o_pop_data,
    input  logic     i_pop
);

    payload_t   r_slot [2];
    logic       r_wr_ptr;
    logic       r_rd_ptr;
    logic [1:0] r_count;
    logic       r_push_ready;
    logic       w_push;
    logic [1:0] w_count_next;

    assign w_push       = i_push_valid && r_push_ready;
    assign w_count_next = r_count + 2'(w_push) - 2'(i_pop);

    assign o_push_ready = r_push_ready;
    assign o_pop_valid  = (r_count != 2'd0);
    assign o_pop_data   = r_slot[r_rd_ptr];

    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_wr_ptr     <= 1'b0;
            r_rd_ptr     <= 1'b0;
            r_count      <= 2'd0;
            r_push_ready <= 1'b1;
        end else begin
            if (w_push) begin
                r_wr_ptr <= !r_wr_ptr;
            end
            if (i_pop) begin
                r_rd_ptr <= !r_rd_ptr;
            end
            r_count <= w_count_next;
            // Ready falls as the second slot fills
            r_push_ready <= (w_count_next != 2'd2);
        end
    end

    always_ff @(posedge i_aclk) begin
        if (w_push) begin
            r_slot[r_wr_ptr] <= i_push_data;
        end
    end

    // Consumer pops only a held command
    a_no_pop_empty: assert property (@(posedge i_aclk) disable iff (!i_areset_n)
        i_pop |-> o_pop_valid);

    // Master keeps valid and payload while stalled
    a_push_stable: assert property (@(posedge i_aclk) disable iff (!i_areset_n)
        i_push_valid && !o_push_ready |=> i_push_valid && $stable(i_push_data));

endmodule

/* hdl/sram_pkg.sv */
`include "sram_defines.svh"

package sram_pkg;

    // AXI4 burst encodings
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10,
        BURST_RSVD  = 2'b11
    } burst_e;

    // Only the two responses this slave ever returns
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    // One accepted AR or AW command
    typedef struct packed {
        logic [`SRAM_ID_W-1:0]   id;
        logic [`SRAM_ADDR_W-1:0] addr;
        logic [7:0]              len;
        logic [2:0]              size;
        burst_e                  burst;
    } addr_cmd_t;

endpackage

/* include/sram_defines.svh */
`ifndef SRAM_DEFINES_SVH
`define SRAM_DEFINES_SVH

// Data path
`define SRAM_DATA_W 64
`define SRAM_STRB_W 8

// 2 KB byte address space
`define SRAM_ADDR_W 11
`define SRAM_DEPTH  256

// Transaction tag
`define SRAM_ID_W   4

`endif
